//--- all.f
riscPkg.sv
controlIf.sv
controlUnit.sv
fetchUnit.sv
registerFile.sv
alu.sv
immediateExtractor.sv
executionDatapath.sv
riscCore.sv
clockGen.sv
tbRiscCore.sv

//--- alu.sv
`timescale 1ns/1ps

module alu import riscPkg::*; (
    input aluOpT op,
    input logic [XLEN-1:0] left,
    input logic [XLEN-1:0] right,
    output logic [XLEN-1:0] result
);

    // Shift amount from the low five bits
    logic [4:0] shamt;

    assign shamt = right[4:0];

    always_comb begin
        case (op)
            ADD:  result = left + right;
            SUB:  result = left - right;
            SLL:  result = left << shamt;
            // Comparisons give 1 or 0
            SLT:  result = XLEN'($signed(left) < $signed(right));
            SLTU: result = XLEN'(left < right);
            XOR:  result = left ^ right;
            SRL:  result = left >> shamt;
            // Sign bit fills from the left
            SRA:  result = $signed(left) >>> shamt;
            OR:   result = left | right;
            AND:  result = left & right;
            default: result = '0;
        endcase
    end

endmodule

//--- clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for the first 10 cycles
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- controlIf.sv
`timescale 1ns/1ps

interface controlIf import riscPkg::*; ();

    // Datapath controls
    aluOpT aluOp;
    aluSrcT aluSrc;
    logic regWriteEnable;
    regSrcT regSrc;
    logic memWrite;

    // Fetch sequencing, picked up at the top level
    logic pcWrite;
    logic fetch;

    // Control unit side drives everything
    modport ctrl (
        output aluOp, aluSrc, regWriteEnable, regSrc, memWrite, pcWrite, fetch
    );

    // Datapath side
    modport dp (
        input aluOp, aluSrc, regWriteEnable, regSrc, memWrite
    );

endinterface

//--- controlUnit.sv
`timescale 1ns/1ps

module controlUnit import riscPkg::*; (
    input logic clk,
    input logic rst,
    input logic [XLEN-1:0] instruction,
    controlIf.ctrl ctl,
    output logic coreError
);

    coreState state;
    coreState nextState;

    // Instruction fields
    opcodeT opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Decoded values, only acted on in WRITE
    logic legal;
    aluOpT decAluOp;
    aluSrcT decAluSrc;
    regSrcT decRegSrc;
    logic decRegWrite;
    logic decMemWrite;
    logic writeStep;

    assign opcode = opcodeT'(instruction[opcodeLsb +: 7]);
    assign funct3 = instruction[funct3Lsb +: 3];
    assign funct7 = instruction[funct7Lsb +: 7];

    // Fixed three-cycle sequence after two reset steps
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET0;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            RESET0:    nextState = RESET1;
            RESET1:    nextState = READ_INST;
            READ_INST: nextState = READ;
            READ:      nextState = WRITE;
            // Illegal word traps here
            WRITE:     nextState = legal ? READ_INST : ERROR;
            // ERROR is sticky
            default:   nextState = ERROR;
        endcase
    end

    // Decoder
    always_comb begin
        legal = 1'b0;
        decAluOp = ADD;
        decAluSrc = IMMEDIATE;
        decRegSrc = ALU_RESULT;
        decRegWrite = 1'b0;
        decMemWrite = 1'b0;
        case (opcode)
            LUI: begin
                legal = 1'b1;
                decRegWrite = 1'b1;
                decRegSrc = UPPER_IMMEDIATE;
            end
            // Word access only
            LOAD: begin
                legal = (funct3 == 3'b010);
                decRegWrite = 1'b1;
                decRegSrc = MAIN_MEMORY;
            end
            STORE: begin
                legal = (funct3 == 3'b010);
                decMemWrite = 1'b1;
            end
            OP_IMM: begin
                decRegWrite = 1'b1;
                case (funct3)
                    3'b001:  legal = (funct7 == 7'b0000000);
                    3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default: legal = 1'b1;
                endcase
                // Alternate bit only for right shifts, keeps addi an add
                decAluOp = aluOpT'({instruction[altBit] & (funct3 == 3'b101), funct3});
            end
            OP: begin
                decRegWrite = 1'b1;
                decAluSrc = REGISTER;
                // sub and sra are the only alternate forms
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                decAluOp = aluOpT'({instruction[altBit], funct3});
            end
            default: legal = 1'b0;
        endcase
    end

    // Side effects only in WRITE and only for a legal word
    assign writeStep = (state == WRITE) && legal;

    assign ctl.fetch = (state == READ_INST);
    assign ctl.pcWrite = writeStep;
    assign ctl.regWriteEnable = writeStep && decRegWrite;
    assign ctl.memWrite = writeStep && decMemWrite;
    assign ctl.aluOp = decAluOp;
    assign ctl.aluSrc = decAluSrc;
    assign ctl.regSrc = decRegSrc;

    assign coreError = (state == ERROR);

endmodule

//--- executionDatapath.sv
`timescale 1ns/1ps

module executionDatapath import riscPkg::*; (
    input logic clk,
    input logic [XLEN-1:0] instruction,
    controlIf.dp ctl,
    input logic [XLEN-1:0] busRdData,
    output logic [XLEN-1:0] busAddress,
    output logic [XLEN-1:0] busWrData,
    output logic busWrEnable
);

    // Register indexes
    logic [regIdxWidth-1:0] rs1;
    logic [regIdxWidth-1:0] rs2;
    logic [regIdxWidth-1:0] rd;

    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] immediate;
    logic [XLEN-1:0] aluRight;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] upperImmediate;
    logic [XLEN-1:0] writeBack;

    assign rs1 = instruction[rs1Lsb +: regIdxWidth];
    assign rs2 = instruction[rs2Lsb +: regIdxWidth];
    assign rd = instruction[rdLsb +: regIdxWidth];

    // LUI value, low twelve bits cleared
    assign upperImmediate = {instruction[XLEN-1:12], 12'b0};

    registerFile regs (
        .clk(clk),
        .readAddrA(rs1),
        .readAddrB(rs2),
        .readDataA(rs1Data),
        .readDataB(rs2Data),
        .writeEnable(ctl.regWriteEnable),
        .writeAddr(rd),
        .writeData(writeBack)
    );

    immediateExtractor immGen (
        .instruction(instruction),
        .immediate(immediate)
    );

    // Right operand select
    assign aluRight = (ctl.aluSrc == IMMEDIATE) ? immediate : rs2Data;

    alu aluUnit (
        .op(ctl.aluOp),
        .left(rs1Data),
        .right(aluRight),
        .result(aluResult)
    );

    // Write-back select
    always_comb begin
        case (ctl.regSrc)
            UPPER_IMMEDIATE: writeBack = upperImmediate;
            MAIN_MEMORY:     writeBack = busRdData;
            default:         writeBack = aluResult;
        endcase
    end

    // Data bus, address from the ALU, store data from rs2
    assign busAddress = aluResult;
    assign busWrData = rs2Data;
    assign busWrEnable = ctl.memWrite;

endmodule

//--- fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import riscPkg::*; #(
    parameter int imemAddrWidth = 32,
    parameter logic [imemAddrWidth-1:0] resetVector = '0
) (
    input logic clk,
    input logic rst,
    input logic fetch,
    input logic pcWrite,
    input logic [XLEN-1:0] imemData,
    output logic [imemAddrWidth-1:0] imemAddr,
    output logic [XLEN-1:0] instruction
);

    logic [imemAddrWidth-1:0] pc;

    // Program counter, one word per instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetVector;
        end else if (pcWrite) begin
            pc <= pc + imemAddrWidth'(4);
        end
    end

    // Instruction register, held through READ and WRITE
    always_ff @(posedge clk) begin
        if (fetch) begin
            instruction <= imemData;
        end
    end

    assign imemAddr = pc;

endmodule

//--- immediateExtractor.sv
`timescale 1ns/1ps

module immediateExtractor import riscPkg::*; (
    input logic [XLEN-1:0] instruction,
    output logic [XLEN-1:0] immediate
);

    opcodeT opcode;
    logic [2:0] funct3;

    assign opcode = opcodeT'(instruction[opcodeLsb +: 7]);
    assign funct3 = instruction[funct3Lsb +: 3];

    always_comb begin
        case (opcode)
            OP_IMM: begin
                // Shifts take a plain five-bit amount
                if ((funct3 == 3'b001) || (funct3 == 3'b101)) begin
                    immediate = {27'b0, instruction[rs2Lsb +: 5]};
                end else begin
                    immediate = {{20{instruction[XLEN-1]}}, instruction[rs2Lsb +: 12]};
                end
            end
            // I-type for loads
            LOAD:    immediate = {{20{instruction[XLEN-1]}}, instruction[rs2Lsb +: 12]};
            // S-type, split offset
            STORE:   immediate = {{20{instruction[XLEN-1]}}, instruction[funct7Lsb +: 7],
                                  instruction[rdLsb +: 5]};
            default: immediate = '0;
        endcase
    end

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile import riscPkg::*; (
    input logic clk,
    input logic [regIdxWidth-1:0] readAddrA,
    input logic [regIdxWidth-1:0] readAddrB,
    output logic [XLEN-1:0] readDataA,
    output logic [XLEN-1:0] readDataB,
    input logic writeEnable,
    input logic [regIdxWidth-1:0] writeAddr,
    input logic [XLEN-1:0] writeData
);

    // x1 to x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        // Writes to x0 are dropped
        if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational reads
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- riscCore.sv
`timescale 1ns/1ps

module riscCore import riscPkg::*; #(
    parameter int imemAddrWidth = 32,
    parameter logic [imemAddrWidth-1:0] resetVector = '0
) (
    input logic clk,
    input logic rst,
    output logic [imemAddrWidth-1:0] imemAddr,
    input logic [XLEN-1:0] imemData,
    output logic [XLEN-1:0] busAddress,
    output logic [XLEN-1:0] busWrData,
    input logic [XLEN-1:0] busRdData,
    output logic busWrEnable,
    output logic coreError
);

    // Current instruction from the fetch stage
    logic [XLEN-1:0] instruction;

    controlIf ctlBus ();

    controlUnit control (
        .clk(clk),
        .rst(rst),
        .instruction(instruction),
        .ctl(ctlBus),
        .coreError(coreError)
    );

    // Only fetch and pcWrite needed here
    fetchUnit #(
        .imemAddrWidth(imemAddrWidth),
        .resetVector(resetVector)
    ) fetcher (
        .clk(clk),
        .rst(rst),
        .fetch(ctlBus.fetch),
        .pcWrite(ctlBus.pcWrite),
        .imemData(imemData),
        .imemAddr(imemAddr),
        .instruction(instruction)
    );

    executionDatapath datapath (
        .clk(clk),
        .instruction(instruction),
        .ctl(ctlBus),
        .busRdData(busRdData),
        .busAddress(busAddress),
        .busWrData(busWrData),
        .busWrEnable(busWrEnable)
    );

endmodule

//--- riscPkg.sv
package riscPkg;

    // Machine word width
    localparam int XLEN = 32;
    // Register index width, 32 architectural registers
    localparam int regIdxWidth = 5;

    // Instruction word field positions
    localparam int opcodeLsb = 0;
    localparam int rdLsb = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb = 15;
    localparam int rs2Lsb = 20;
    localparam int funct7Lsb = 25;
    // funct7 bit 5, picks sub and sra
    localparam int altBit = 30;

    // Sequencer states
    typedef enum logic [2:0] {RESET0, RESET1, READ_INST, READ, WRITE, ERROR} coreState;

    // Supported major opcodes
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcodeT;

    // Alternate bit followed by funct3
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } aluOpT;

    // ALU right operand
    typedef enum logic {REGISTER, IMMEDIATE} aluSrcT;

    // Register write-back source
    typedef enum logic [1:0] {ALU_RESULT, UPPER_IMMEDIATE, MAIN_MEMORY} regSrcT;

endpackage

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tbRiscCore -f all.f -o simRiscCore \
    && ./obj_dir/simRiscCore | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tbRiscCore.sv
`timescale 1ns/1ps

module tbRiscCore;

    // Random part, register dump, one illegal word
    localparam int randomCount = 200;
    localparam int progLength = randomCount + 32 + 1;
    localparam int illegalIndex = progLength - 1;
    // Run limit in ns, three cycles per instruction, doubled
    localparam int watchdogNs = (progLength + 10) * 3 * 10 * 2;

    logic clk;
    logic rst;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] busAddress;
    logic [31:0] busWrData;
    logic [31:0] busRdData;
    logic busWrEnable;
    logic coreError;

    integer seed;
    logic [31:0] progMem [0:255];
    logic [31:0] dataMem [0:127];

    // Reference model state
    logic [31:0] modelRegs [0:31];
    logic [31:0] modelMem [0:127];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];

    // Monitor state
    int storeCount;
    logic started;
    logic errorSeen;
    logic [31:0] lastAddr;

    clockGen clocks (
        .clk(clk),
        .rst(rst)
    );

    riscCore #(
        .imemAddrWidth(32),
        .resetVector(32'h0)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .busAddress(busAddress),
        .busWrData(busWrData),
        .busRdData(busRdData),
        .busWrEnable(busWrEnable),
        .coreError(coreError)
    );

    // Both memories answer in the same cycle
    assign imemData = progMem[imemAddr[9:2]];
    assign busRdData = dataMem[busAddress[8:2]];

    always @(posedge clk) begin
        if (busWrEnable) begin
            dataMem[busAddress[8:2]] <= busWrData;
        end
    end

    task automatic reportProblem(input string what);
        $display("%s at %0t ns", what, $time);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    // Same random contents in the DUT memory and the model memory
    task automatic fillDataMemory;
        logic [31:0] value;
        for (int i = 0; i < 128; i++) begin
            value = $random(seed);
            dataMem[i] = value;
            modelMem[i] = value;
        end
    endtask

    task automatic buildProgram;
        logic [31:0] pick;
        logic [31:0] pick2;
        logic [11:0] off;
        logic [2:0] f3;
        logic alt;
        int kind;
        for (int i = 0; i < 256; i++) begin
            progMem[i] = 32'h0;
        end
        for (int i = 0; i < randomCount; i++) begin
            pick = $random(seed);
            pick2 = $random(seed);
            f3 = pick[14:12];
            off = {4'b0, pick[25:20], 2'b00};
            kind = pick2 % 32'd5;
            if (i < 31) begin
                // addi x(i+1), x0, imm so that no register is read undefined
                progMem[i] = {pick[31:20], 5'd0, 3'b000, 5'(i + 1), 7'b0010011};
            end else begin
                case (kind)
                    0: progMem[i] = {pick[31:7], 7'b0110111};
                    // Loads and stores on x0, word offset below 256
                    1: progMem[i] = {off, 5'd0, 3'b010, pick[11:7], 7'b0000011};
                    2: progMem[i] = {off[11:5], pick2[12:8], 5'd0, 3'b010, off[4:0],
                                     7'b0100011};
                    3: begin
                        if (f3 == 3'b001) begin
                            progMem[i] = {7'b0000000, pick[24:7], 7'b0010011};
                        end else if (f3 == 3'b101) begin
                            progMem[i] = {1'b0, pick2[7], 5'b0, pick[24:7], 7'b0010011};
                        end else begin
                            progMem[i] = {pick[31:7], 7'b0010011};
                        end
                    end
                    default: begin
                        // sub and sra are the only alternate forms
                        alt = pick2[7] & ((f3 == 3'b000) || (f3 == 3'b101));
                        progMem[i] = {1'b0, alt, 5'b0, pick[24:7], 7'b0110011};
                    end
                endcase
            end
        end
        // sw xi, 256+4i(x0)
        for (int i = 0; i < 32; i++) begin
            off = 12'(256 + 4 * i);
            progMem[randomCount + i] = {off[11:5], 5'(i), 5'd0, 3'b010, off[4:0], 7'b0100011};
        end
        progMem[illegalIndex] = 32'h0;
    endtask

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes every legal word, collects the expected stores
    task automatic runModel;
        logic [31:0] word;
        logic [31:0] result;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        logic [4:0] rd;
        logic writes;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0;
        end
        for (int k = 0; k < illegalIndex; k++) begin
            word = progMem[k];
            rd = word[11:7];
            immI = {{20{word[31]}}, word[31:20]};
            immS = {{20{word[31]}}, word[31:25], word[11:7]};
            writes = 1'b1;
            result = 32'h0;
            case (word[6:0])
                7'b0110111: result = {word[31:12], 12'b0};
                7'b0000011: begin
                    addr = modelRegs[word[19:15]] + immI;
                    result = modelMem[addr[8:2]];
                end
                7'b0100011: begin
                    writes = 1'b0;
                    addr = modelRegs[word[19:15]] + immS;
                    expAddr.push_back(addr);
                    expData.push_back(modelRegs[word[24:20]]);
                    modelMem[addr[8:2]] = modelRegs[word[24:20]];
                end
                // Alternate bit only counts for right shifts
                7'b0010011: result = aluModel(word[14:12], word[30] & (word[14:12] == 3'b101),
                                              modelRegs[word[19:15]], immI);
                default: result = aluModel(word[14:12], word[30], modelRegs[word[19:15]],
                                           modelRegs[word[24:20]]);
            endcase
            // x0 keeps zero
            if (writes && (rd != 5'd0)) begin
                modelRegs[rd] = result;
            end
        end
    endtask

    // Outputs sampled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (!started) begin
                compareValue("coreError", {31'b0, coreError}, 32'h0);
                compareValue("busWrEnable", {31'b0, busWrEnable}, 32'h0);
                compareValue("imemAddr", imemAddr, 32'h0);
                started = 1'b1;
                lastAddr = imemAddr;
            end else if (imemAddr != lastAddr) begin
                if (errorSeen) begin
                    reportProblem("Instruction address moved after the error state");
                end else begin
                    compareValue("imemAddr", imemAddr, lastAddr + 32'd4);
                    lastAddr = imemAddr;
                end
            end
            if (busWrEnable) begin
                if (errorSeen || (storeCount >= expAddr.size())) begin
                    reportProblem("Store seen beyond the expected stores");
                end else begin
                    compareValue("busAddress", busAddress, expAddr[storeCount]);
                    compareValue("busWrData", busWrData, expData[storeCount]);
                    storeCount++;
                end
            end
            if (coreError && !errorSeen) begin
                errorSeen = 1'b1;
                // Trap at the illegal word, pc not advanced
                compareValue("imemAddr", imemAddr, 32'(4 * illegalIndex));
            end
        end
    end

    initial begin
        #(watchdogNs);
        reportProblem("Watchdog expired, the core did not reach the error state");
    end

    initial begin
        seed = 32'h130026d4;
        storeCount = 0;
        started = 1'b0;
        errorSeen = 1'b0;
        lastAddr = 32'h0;
        fillDataMemory();
        buildProgram();
        runModel();
        wait (errorSeen === 1'b1);
        // Stay a while to see the core remain stopped
        repeat (20) @(negedge clk);
        if (storeCount == expAddr.size()) begin
            $display("TEST OK");
            $finish;
        end else begin
            reportProblem("Fewer stores seen than the model expects");
        end
    end

endmodule
